// ==== tb.f ====
verilog/riscvPkg.sv
verilog/branchPredictor.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/controller.sv
verilog/hazardUnit.sv
verilog/datapath.sv
verilog/dataMemory.sv
verilog/riscvCore.sv
dv/tbClock.sv
dv/tbTop.sv

// ==== dv/tbTop.sv ====
`default_nettype none

module tbTop;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          ProgWords      = 51;
    localparam int          TimeoutCycles  = 2000;
    localparam int          ResetTimeout   = 20;
    localparam int          DrainCycles    = 10;
    localparam int          FirstStoreEdge = 15;  // sw at word 11, memory stage 4 edges later
    localparam logic [31:0] NopWord        = 32'h0000_0013;  // addi x0, x0, 0
    localparam logic [31:0] MarkerAddr     = 32'h0000_00FC;
    localparam logic [31:0] ResetPc        = 32'h0000_0000;
    localparam logic [6:0]  OpImm          = 7'b0010011;
    localparam logic [6:0]  OpLoad         = 7'b0000011;

    logic        clk, reset;
    logic [31:0] instrAddr, instr, memAddr, memWData;
    logic        memWe;
    logic [29:0] wordIdx;
    logic [31:0] rom [ProgWords];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    int          errors, storeIdx, edgeCount;
    logic        markerSeen;

    tbClock u_clock (.clk_o(clk), .reset_o(reset));

    riscvCore u_dut (
        .clk(clk), .reset(reset),
        .instrAddr_o(instrAddr), .instr_i(instr),
        .memWe_o(memWe), .memAddr_o(memAddr), .memWData_o(memWData)
    );

    // Program ROM, answers in the same cycle
    assign wordIdx = instrAddr[31:2];
    assign instr   = (wordIdx < ProgWords) ? rom[wordIdx[5:0]] : NopWord;

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                          input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] uType(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic loadProgram();
        rom[0]  = iType(OpImm, 3'b000, 1, 0, 12'h06C);    // x1 = 108
        rom[1]  = iType(OpImm, 3'b000, 2, 0, 12'hFFD);    // x2 = -3
        rom[2]  = rType(7'h00, 3'b000, 3, 1, 2);          // add, both operands forwarded
        rom[3]  = rType(7'h20, 3'b000, 4, 2, 3);          // sub x4 = x2 - x3
        rom[4]  = rType(7'h00, 3'b010, 5, 4, 1);          // slt neg < pos
        rom[5]  = rType(7'h00, 3'b010, 6, 1, 4);          // slt pos < neg
        rom[6]  = rType(7'h00, 3'b010, 10, 4, 2);         // slt neg < neg
        rom[7]  = rType(7'h00, 3'b110, 7, 1, 4);          // or
        rom[8]  = rType(7'h00, 3'b111, 8, 1, 4);          // and
        rom[9]  = uType(9, 20'h12345);
        rom[10] = iType(OpImm, 3'b000, 9, 9, 12'h678);    // Uses the lui result
        rom[11] = sType(9, 0, 12'h000);                   // First store of the program
        rom[12] = sType(3, 0, 12'h004);
        rom[13] = sType(4, 0, 12'h008);
        rom[14] = sType(5, 0, 12'h00C);
        rom[15] = sType(6, 0, 12'h010);
        rom[16] = sType(10, 0, 12'h014);
        rom[17] = sType(7, 0, 12'h018);
        rom[18] = sType(8, 0, 12'h01C);
        // Load-use pairs
        rom[19] = iType(OpLoad, 3'b010, 11, 0, 12'h004);
        rom[20] = rType(7'h00, 3'b000, 12, 11, 1);
        rom[21] = sType(12, 0, 12'h020);
        rom[22] = iType(OpLoad, 3'b010, 13, 0, 12'h000);
        rom[23] = sType(13, 0, 12'h024);                  // Store data is the loaded word
        // Counted bne loop, ten passes
        rom[24] = iType(OpImm, 3'b000, 14, 0, 12'h000);   // Sum
        rom[25] = iType(OpImm, 3'b000, 15, 0, 12'h00A);   // Counter
        rom[26] = iType(OpImm, 3'b000, 16, 0, 12'h040);   // Store pointer
        rom[27] = rType(7'h00, 3'b000, 14, 14, 15);
        rom[28] = sType(14, 16, 12'h000);
        rom[29] = iType(OpImm, 3'b000, 16, 16, 12'h004);
        rom[30] = iType(OpImm, 3'b000, 15, 15, 12'hFFF);
        rom[31] = bType(3'b001, 15, 0, 13'h1FF0);         // bne back to word 27
        rom[32] = sType(14, 0, 12'h068);
        // beq not taken, then taken
        rom[33] = bType(3'b000, 5, 6, 13'd8);
        rom[34] = sType(5, 0, 12'h06C);
        rom[35] = bType(3'b000, 6, 0, 13'd12);            // To word 38
        rom[36] = sType(1, 0, 12'h070);                   // Skipped
        rom[37] = sType(2, 0, 12'h074);                   // Skipped
        rom[38] = sType(8, 0, 12'h078);
        // Outer loop around a forward jal
        rom[39] = iType(OpImm, 3'b000, 17, 0, 12'h002);
        rom[40] = iType(OpImm, 3'b000, 18, 0, 12'h080);
        rom[41] = jType(19, 21'd12);                      // To word 44, link 0xA8
        rom[42] = sType(1, 0, 12'h07C);                   // Skipped
        rom[43] = sType(2, 0, 12'h07C);                   // Skipped
        rom[44] = sType(19, 18, 12'h000);
        rom[45] = iType(OpImm, 3'b000, 18, 18, 12'h004);
        rom[46] = iType(OpImm, 3'b000, 17, 17, 12'hFFF);
        rom[47] = bType(3'b001, 17, 0, 13'h1FE8);         // bne back to word 41
        rom[48] = iType(OpImm, 3'b000, 20, 0, 12'h5A5);
        rom[49] = sType(20, 0, 12'h0FC);                  // End marker
        rom[50] = jType(0, 21'd0);                        // Spin here
    endtask

    task automatic expectStore(input logic [31:0] addr, input logic [31:0] data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic loadExpected();
        logic [31:0] sum;
        expectStore(32'h00, 32'h1234_5678);
        expectStore(32'h04, 32'h0000_0069);  // 108 - 3
        expectStore(32'h08, 32'hFFFF_FF94);  // -3 - 105
        expectStore(32'h0C, 32'h0000_0001);
        expectStore(32'h10, 32'h0000_0000);
        expectStore(32'h14, 32'h0000_0001);
        expectStore(32'h18, 32'hFFFF_FFFC);
        expectStore(32'h1C, 32'h0000_0004);
        expectStore(32'h20, 32'h0000_00D5);  // Loaded 0x69 plus 0x6C
        expectStore(32'h24, 32'h1234_5678);
        sum = 0;
        for (int c = 10; c >= 1; c--) begin
            sum = sum + c;
            expectStore(32'h40 + 4 * (10 - c), sum);
        end
        expectStore(32'h68, 32'd55);
        expectStore(32'h6C, 32'h0000_0001);
        expectStore(32'h78, 32'h0000_0004);
        expectStore(32'h80, 32'h0000_00A8);  // Link of jal at 0xA4
        expectStore(32'h84, 32'h0000_00A8);
        expectStore(MarkerAddr, 32'h0000_05A5);
    endtask

    task automatic checkStore();
        if (storeIdx >= expAddr.size()) begin
            errors++;
            $display("Unexpected extra store to 0x%08h with data 0x%08h", memAddr, memWData);
        end else begin
            if (storeIdx == 0) begin
                assert (edgeCount == FirstStoreEdge) else begin
                    errors++;
                    $display("First store arrived at cycle %0d instead of cycle %0d",
                             edgeCount, FirstStoreEdge);
                end
            end
            assert (memAddr === expAddr[storeIdx]) else begin
                errors++;
                $display("ERROR memAddr_o: store %0d got 0x%08h expected 0x%08h",
                         storeIdx, memAddr, expAddr[storeIdx]);
            end
            assert (memWData === expData[storeIdx]) else begin
                errors++;
                $display("ERROR memWData_o: store %0d got 0x%08h expected 0x%08h",
                         storeIdx, memWData, expData[storeIdx]);
            end
            storeIdx++;
        end
        if (memAddr === MarkerAddr)
            markerSeen = 1'b1;
    endtask

    // Store monitor, sees the memory stage of the cycle just ended
    always @(posedge clk) begin
        if (reset === 1'b0) begin
            edgeCount++;
            if (edgeCount == 1) begin
                assert (instrAddr === ResetPc) else begin  // Fetch address held by reset
                    errors++;
                    $display("ERROR instrAddr_o: got 0x%08h expected 0x%08h after reset",
                             instrAddr, ResetPc);
                end
            end
            if (edgeCount < FirstStoreEdge) begin
                assert (memWe === 1'b0) else begin
                    errors++;
                    $display("ERROR memWe_o: got 0x%0h expected 0x0 at cycle %0d",
                             memWe, edgeCount);
                end
            end
            if (memWe === 1'b1)
                checkStore();
        end
    end

    task automatic waitForReset();
        int n;
        n = 0;
        while (reset !== 1'b0 && n < ResetTimeout) begin
            @(negedge clk);
            n++;
        end
        if (reset !== 1'b0) begin
            errors++;
            $display("Reset was still asserted after %0d cycles", ResetTimeout);
        end
    endtask

    task automatic waitForMarker();
        int n;
        n = 0;
        while (!markerSeen && n < TimeoutCycles) begin
            @(negedge clk);
            n++;
        end
        if (!markerSeen) begin
            errors++;
            $display("Timed out after %0d cycles waiting for the store to 0x%08h",
                     TimeoutCycles, MarkerAddr);
        end
    endtask

    initial begin
        errors     = 0;
        storeIdx   = 0;
        edgeCount  = 0;
        markerSeen = 1'b0;
        loadProgram();
        loadExpected();
        waitForReset();
        waitForMarker();
        repeat (DrainCycles) @(negedge clk);  // Catch stray stores after the marker
        if (storeIdx < expAddr.size()) begin
            errors++;
            $display("Missing stores, only %0d of %0d arrived", storeIdx, expAddr.size());
        end
        $display("Stores checked: %0d of %0d, errors: %0d", storeIdx, expAddr.size(), errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tbClock.sv ====
`default_nettype none

module tbClock (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HalfPeriod  = 2;  // 4 ns clock
    localparam int ResetCycles = 5;

    initial begin
        clk_o = 1'b0;
        forever #HalfPeriod clk_o = ~clk_o;
    end

    // Released on a falling edge like every other input
    initial begin
        reset_o = 1'b1;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verilog/riscvCore.sv ====
`default_nettype none

module riscvCore import riscvPkg::*; (
    input  logic  clk,
    input  logic  reset,
    output word_t instrAddr_o,
    input  word_t instr_i,
    output logic  memWe_o,
    output word_t memAddr_o,
    output word_t memWData_o
);

    logic [6:0] op;
    logic [2:0] funct3, funct3E;
    logic       funct7b5, aluSrcE, branchE, jumpE;
    logic       memWriteM, regWriteM, regWriteW, mispredict;
    logic       stallF, stallD, flushD, flushE;
    immSrc_e    immSrcD;
    aluOp_e     aluControlE;
    resultSrc_e resultSrcE, resultSrcM, resultSrcW;
    fwd_e       forwardAE, forwardBE;
    regAddr_t   rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW;
    word_t      aluResultM, writeDataM, readDataM;

    // Store port seen by the testbench
    assign memWe_o    = memWriteM;
    assign memAddr_o  = aluResultM;
    assign memWData_o = writeDataM;

    datapath u_datapath (
        .clk(clk), .reset(reset),
        .stallF_i(stallF), .stallD_i(stallD), .flushD_i(flushD), .flushE_i(flushE),
        .instr_i(instr_i), .pcF_o(instrAddr_o),
        .op_o(op), .funct3_o(funct3), .funct7b5_o(funct7b5),
        .immSrcD_i(immSrcD), .aluSrcE_i(aluSrcE), .aluControlE_i(aluControlE),
        .branchE_i(branchE), .jumpE_i(jumpE), .funct3E_i(funct3E),
        .forwardAE_i(forwardAE), .forwardBE_i(forwardBE),
        .resultSrcM_i(resultSrcM), .resultSrcW_i(resultSrcW), .regWriteW_i(regWriteW),
        .rs1D_o(rs1D), .rs2D_o(rs2D), .rs1E_o(rs1E), .rs2E_o(rs2E),
        .rdE_o(rdE), .rdM_o(rdM), .rdW_o(rdW),
        .mispredict_o(mispredict),
        .aluResultM_o(aluResultM), .writeDataM_o(writeDataM), .readDataM_i(readDataM)
    );

    controller u_controller (
        .clk(clk), .reset(reset),
        .op_i(op), .funct3_i(funct3), .funct7b5_i(funct7b5), .flushE_i(flushE),
        .immSrcD_o(immSrcD), .aluSrcE_o(aluSrcE), .aluControlE_o(aluControlE),
        .branchE_o(branchE), .jumpE_o(jumpE), .funct3E_o(funct3E),
        .resultSrcE_o(resultSrcE), .resultSrcM_o(resultSrcM), .resultSrcW_o(resultSrcW),
        .memWriteM_o(memWriteM), .regWriteM_o(regWriteM), .regWriteW_o(regWriteW)
    );

    hazardUnit u_hazard (
        .rs1D_i(rs1D), .rs2D_i(rs2D), .rs1E_i(rs1E), .rs2E_i(rs2E),
        .rdE_i(rdE), .rdM_i(rdM), .rdW_i(rdW),
        .resultSrcE_i(resultSrcE), .regWriteM_i(regWriteM), .regWriteW_i(regWriteW),
        .mispredict_i(mispredict),
        .stallF_o(stallF), .stallD_o(stallD), .flushD_o(flushD), .flushE_o(flushE),
        .forwardAE_o(forwardAE), .forwardBE_o(forwardBE)
    );

    dataMemory u_dmem (
        .clk(clk), .we_i(memWriteM), .addr_i(aluResultM),
        .wd_i(writeDataM), .rd_o(readDataM)
    );

endmodule

`default_nettype wire

// ==== verilog/dataMemory.sv ====
`default_nettype none

module dataMemory import riscvPkg::*; (
    input  logic  clk,
    input  logic  we_i,
    input  word_t addr_i,
    input  word_t wd_i,
    output word_t rd_o
);

    word_t                        mem [DmemWords];
    logic [$clog2(DmemWords)-1:0] wordIdx;

    assign wordIdx = addr_i[$clog2(DmemWords)+1:2];  // Word aligned only

    always_ff @(posedge clk) begin
        if (we_i)
            mem[wordIdx] <= wd_i;
    end

    assign rd_o = mem[wordIdx];

endmodule

`default_nettype wire

// ==== verilog/datapath.sv ====
`default_nettype none

module datapath import riscvPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       stallF_i,
    input  logic       stallD_i,
    input  logic       flushD_i,
    input  logic       flushE_i,
    input  word_t      instr_i,
    output word_t      pcF_o,
    output logic [6:0] op_o,
    output logic [2:0] funct3_o,
    output logic       funct7b5_o,
    input  immSrc_e    immSrcD_i,
    input  logic       aluSrcE_i,
    input  aluOp_e     aluControlE_i,
    input  logic       branchE_i,
    input  logic       jumpE_i,
    input  logic [2:0] funct3E_i,
    input  fwd_e       forwardAE_i,
    input  fwd_e       forwardBE_i,
    input  resultSrc_e resultSrcM_i,
    input  resultSrc_e resultSrcW_i,
    input  logic       regWriteW_i,
    output regAddr_t   rs1D_o, rs2D_o, rs1E_o, rs2E_o,
    output regAddr_t   rdE_o, rdM_o, rdW_o,
    output logic       mispredict_o,
    output word_t      aluResultM_o,
    output word_t      writeDataM_o,
    input  word_t      readDataM_i
);

    logic               predictTakenF, predTakenD, predTakenE, zeroE, takenE;
    logic [GhrBits-1:0] phtIndexF, phtIndexD, phtIndexE, ghrSeenE, ghrRestoreE;
    word_t              predictTargetF, pcPlus4F, pcNextF;
    word_t              instrD, pcD, pcPlus4D, immD, rd1D, rd2D;
    word_t              rd1E, rd2E, pcE, pcPlus4E, immE, srcAE, srcBE;
    word_t              writeDataE, aluResultE, pcTargetE;
    word_t              pcPlus4M, immM, forwardDataM;
    word_t              aluResultW, readDataW, pcPlus4W, immW, resultW;

    branchPredictor u_predictor (
        .clk(clk), .reset(reset), .pc_i(pcF_o), .opD_i(op_o),
        .btbWe_i(takenE), .btbIdx_i(pcE[BtbIdxBits+1:2]), .btbTarget_i(pcTargetE),
        .phtWe_i(branchE_i), .phtTaken_i(takenE), .phtIdx_i(phtIndexE),
        .ghrRestore_i(mispredict_o), .ghrRestoreVal_i(ghrRestoreE), .stallF_i(stallF_i),
        .predictTaken_o(predictTakenF), .predictTarget_o(predictTargetF),
        .phtIndex_o(phtIndexF)
    );

    // Fetch
    assign pcPlus4F = pcF_o + 32'd4;

    always_comb begin
        if (mispredict_o)
            pcNextF = takenE ? pcTargetE : pcPlus4E;  // Recovery from execute
        else if (predictTakenF)
            pcNextF = predictTargetF;
        else
            pcNextF = pcPlus4F;
    end

    always_ff @(posedge clk) begin
        if (reset)
            pcF_o <= resetPc;
        else if (!stallF_i)
            pcF_o <= pcNextF;
    end

    // Decode
    always_ff @(posedge clk) begin
        if (reset || flushD_i) begin
            instrD     <= '0;  // Opcode 0 decodes as a bubble
            predTakenD <= 1'b0;
        end else if (!stallD_i) begin
            instrD     <= instr_i;
            predTakenD <= predictTakenF;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallD_i) begin
            pcD       <= pcF_o;
            pcPlus4D  <= pcPlus4F;
            phtIndexD <= phtIndexF;
        end
    end

    assign op_o       = instrD[6:0];
    assign funct3_o   = instrD[14:12];
    assign funct7b5_o = instrD[30];
    assign rs1D_o     = instrD[19:15];
    assign rs2D_o     = instrD[24:20];

    registerFile u_regFile (
        .clk(clk), .a1_i(rs1D_o), .a2_i(rs2D_o), .a3_i(rdW_o),
        .we3_i(regWriteW_i), .wd3_i(resultW), .rd1_o(rd1D), .rd2_o(rd2D)
    );

    always_comb begin
        case (immSrcD_i)
            immS:    immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            immB:    immD = {{20{instrD[31]}}, instrD[7], instrD[30:25], instrD[11:8], 1'b0};
            immJ:    immD = {{12{instrD[31]}}, instrD[19:12], instrD[20], instrD[30:21], 1'b0};
            immU:    immD = {instrD[31:12], 12'b0};
            default: immD = {{20{instrD[31]}}, instrD[31:20]};
        endcase
    end

    // Execute
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            rs1E_o     <= '0;
            rs2E_o     <= '0;
            rdE_o      <= '0;
            predTakenE <= 1'b0;
        end else begin
            rs1E_o     <= rs1D_o;
            rs2E_o     <= rs2D_o;
            rdE_o      <= instrD[11:7];
            predTakenE <= predTakenD;
        end
    end

    always_ff @(posedge clk) begin
        rd1E      <= rd1D;
        rd2E      <= rd2D;
        pcE       <= pcD;
        pcPlus4E  <= pcPlus4D;
        immE      <= immD;
        phtIndexE <= phtIndexD;
    end

    always_comb begin
        case (forwardAE_i)
            fwdMem:  srcAE = forwardDataM;
            fwdWb:   srcAE = resultW;
            default: srcAE = rd1E;
        endcase
        case (forwardBE_i)
            fwdMem:  writeDataE = forwardDataM;
            fwdWb:   writeDataE = resultW;
            default: writeDataE = rd2E;
        endcase
    end

    assign srcBE = aluSrcE_i ? immE : writeDataE;

    alu u_alu (
        .a_i(srcAE), .b_i(srcBE), .aluControl_i(aluControlE_i),
        .result_o(aluResultE), .zero_o(zeroE)
    );

    assign pcTargetE = pcE + immE;

    // True outcome against the prediction carried from fetch
    assign takenE = jumpE_i || (branchE_i && ((funct3E_i == f3Beq && zeroE)
                                           || (funct3E_i == f3Bne && !zeroE)));
    assign mispredict_o = (takenE != predTakenE);

    // History seen at fetch is recovered from the gshare index
    assign ghrSeenE    = phtIndexE ^ pcE[GhrBits+1:2];
    assign ghrRestoreE = branchE_i ? {ghrSeenE[GhrBits-2:0], takenE} : ghrSeenE;

    // Memory
    always_ff @(posedge clk) begin
        if (reset) begin
            rdM_o <= '0;
            rdW_o <= '0;
        end else begin
            rdM_o <= rdE_o;
            rdW_o <= rdM_o;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM_o <= aluResultE;
        writeDataM_o <= writeDataE;
        pcPlus4M     <= pcPlus4E;
        immM         <= immE;
        aluResultW   <= aluResultM_o;
        readDataW    <= readDataM_i;
        pcPlus4W     <= pcPlus4M;
        immW         <= immM;
    end

    always_comb begin
        case (resultSrcM_i)
            resPcPlus4: forwardDataM = pcPlus4M;
            resImm:     forwardDataM = immM;
            default:    forwardDataM = aluResultM_o;  // Loads are covered by the stall
        endcase
    end

    // Writeback
    always_comb begin
        case (resultSrcW_i)
            resMem:     resultW = readDataW;
            resPcPlus4: resultW = pcPlus4W;
            resImm:     resultW = immW;
            default:    resultW = aluResultW;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
`default_nettype none

module hazardUnit import riscvPkg::*; (
    input  regAddr_t   rs1D_i,
    input  regAddr_t   rs2D_i,
    input  regAddr_t   rs1E_i,
    input  regAddr_t   rs2E_i,
    input  regAddr_t   rdE_i,
    input  regAddr_t   rdM_i,
    input  regAddr_t   rdW_i,
    input  resultSrc_e resultSrcE_i,
    input  logic       regWriteM_i,
    input  logic       regWriteW_i,
    input  logic       mispredict_i,
    output logic       stallF_o,
    output logic       stallD_o,
    output logic       flushD_o,
    output logic       flushE_o,
    output fwd_e       forwardAE_o,
    output fwd_e       forwardBE_o
);

    logic loadUse;

    // Memory stage wins over writeback since it is younger
    function automatic fwd_e fwdSelect(input regAddr_t rs, input regAddr_t rdM,
                                       input logic weM, input regAddr_t rdW,
                                       input logic weW);
        if (rs != '0 && rs == rdM && weM)
            return fwdMem;
        else if (rs != '0 && rs == rdW && weW)
            return fwdWb;
        return fwdNone;
    endfunction

    assign forwardAE_o = fwdSelect(rs1E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);
    assign forwardBE_o = fwdSelect(rs2E_i, rdM_i, regWriteM_i, rdW_i, regWriteW_i);

    assign loadUse = (resultSrcE_i == resMem) && (rdE_i != '0)
                     && (rdE_i == rs1D_i || rdE_i == rs2D_i);

    assign stallF_o = loadUse;
    assign stallD_o = loadUse;
    assign flushD_o = mispredict_i;
    assign flushE_o = loadUse || mispredict_i;  // Bubble or wrong path

endmodule

`default_nettype wire

// ==== verilog/controller.sv ====
`default_nettype none

module controller import riscvPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] op_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7b5_i,
    input  logic       flushE_i,
    output immSrc_e    immSrcD_o,
    output logic       aluSrcE_o,
    output aluOp_e     aluControlE_o,
    output logic       branchE_o,
    output logic       jumpE_o,
    output logic [2:0] funct3E_o,
    output resultSrc_e resultSrcE_o,
    output resultSrc_e resultSrcM_o,
    output resultSrc_e resultSrcW_o,
    output logic       memWriteM_o,
    output logic       regWriteM_o,
    output logic       regWriteW_o
);

    logic       regWriteD, memWriteD, aluSrcD, branchD, jumpD;
    resultSrc_e resultSrcD;
    aluOp_e     aluControlD;
    logic       regWriteE, memWriteE;

    // Main decoder
    always_comb begin
        regWriteD  = 1'b0;
        memWriteD  = 1'b0;
        aluSrcD    = 1'b0;
        branchD    = 1'b0;
        jumpD      = 1'b0;
        resultSrcD = resAlu;
        immSrcD_o  = immI;
        case (op_i)
            opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSrcD = resMem;
            end
            opStore: begin
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD_o = immS;
            end
            opOp: regWriteD = 1'b1;
            opOpImm: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
            end
            opLui: begin
                regWriteD  = 1'b1;
                resultSrcD = resImm;
                immSrcD_o  = immU;
            end
            opBranch: begin
                branchD   = 1'b1;
                immSrcD_o = immB;
            end
            opJal: begin
                regWriteD  = 1'b1;
                jumpD      = 1'b1;
                resultSrcD = resPcPlus4;
                immSrcD_o  = immJ;
            end
            default: ;  // Bubble or unsupported, no side effects
        endcase
    end

    // ALU decoder
    always_comb begin
        case (funct3_i)
            3'b010:  aluControlD = aluSlt;
            3'b110:  aluControlD = aluOr;
            3'b111:  aluControlD = aluAnd;
            default: aluControlD = (op_i == opOp && funct7b5_i) ? aluSub : aluAdd;
        endcase
        if (op_i == opBranch)
            aluControlD = aluSub;  // Equality via zero flag
        else if (op_i != opOp && op_i != opOpImm)
            aluControlD = aluAdd;  // Address calc for lw/sw
    end

    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            regWriteE     <= 1'b0;
            memWriteE     <= 1'b0;
            aluSrcE_o     <= 1'b0;
            branchE_o     <= 1'b0;
            jumpE_o       <= 1'b0;
            funct3E_o     <= 3'b0;
            aluControlE_o <= aluAdd;
            resultSrcE_o  <= resAlu;
        end else begin
            regWriteE     <= regWriteD;
            memWriteE     <= memWriteD;
            aluSrcE_o     <= aluSrcD;
            branchE_o     <= branchD;
            jumpE_o       <= jumpD;
            funct3E_o     <= funct3_i;
            aluControlE_o <= aluControlD;
            resultSrcE_o  <= resultSrcD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM_o  <= 1'b0;
            memWriteM_o  <= 1'b0;
            resultSrcM_o <= resAlu;
            regWriteW_o  <= 1'b0;
            resultSrcW_o <= resAlu;
        end else begin
            regWriteM_o  <= regWriteE;
            memWriteM_o  <= memWriteE;
            resultSrcM_o <= resultSrcE_o;
            regWriteW_o  <= regWriteM_o;
            resultSrcW_o <= resultSrcM_o;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu import riscvPkg::*; (
    input  word_t  a_i,
    input  word_t  b_i,
    input  aluOp_e aluControl_i,
    output word_t  result_o,
    output logic   zero_o
);

    always_comb begin
        case (aluControl_i)
            aluAdd:  result_o = a_i + b_i;
            aluSub:  result_o = a_i - b_i;
            aluAnd:  result_o = a_i & b_i;
            aluOr:   result_o = a_i | b_i;
            aluSlt:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            default: result_o = '0;
        endcase
    end

    assign zero_o = (result_o == '0);  // Branch compare

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
`default_nettype none

module registerFile import riscvPkg::*; (
    input  logic     clk,
    input  regAddr_t a1_i,
    input  regAddr_t a2_i,
    input  regAddr_t a3_i,
    input  logic     we3_i,
    input  word_t    wd3_i,
    output word_t    rd1_o,
    output word_t    rd2_o
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we3_i)
            regs[a3_i] <= wd3_i;  // x0 may be written, it is never read
    end

    // Writeback bypass so decode sees the value written this cycle
    assign rd1_o = (a1_i == '0) ? '0 : (we3_i && a3_i == a1_i) ? wd3_i : regs[a1_i];
    assign rd2_o = (a2_i == '0) ? '0 : (we3_i && a3_i == a2_i) ? wd3_i : regs[a2_i];

endmodule

`default_nettype wire

// ==== verilog/branchPredictor.sv ====
`default_nettype none

module branchPredictor import riscvPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  word_t                 pc_i,
    input  logic [6:0]            opD_i,
    input  logic                  btbWe_i,
    input  logic [BtbIdxBits-1:0] btbIdx_i,
    input  word_t                 btbTarget_i,
    input  logic                  phtWe_i,
    input  logic                  phtTaken_i,
    input  logic [GhrBits-1:0]    phtIdx_i,
    input  logic                  ghrRestore_i,
    input  logic [GhrBits-1:0]    ghrRestoreVal_i,
    input  logic                  stallF_i,
    output logic                  predictTaken_o,
    output word_t                 predictTarget_o,
    output logic [GhrBits-1:0]    phtIndex_o
);

    logic                   btbValid [BtbEntries];
    logic                   btbJump [BtbEntries];
    logic [31:BtbIdxBits+2] btbTag [BtbEntries];
    word_t                  btbTarget [BtbEntries];
    logic [1:0]             pht [2**GhrBits];
    logic [GhrBits-1:0]     ghr;
    word_t                  pcD, pcE;  // Follows the fetch PC down to execute for the tag
    logic [6:0]             opE;
    logic                   predTakenD;
    logic [BtbIdxBits-1:0]  idxF;
    logic                   hitF;

    assign idxF = pc_i[BtbIdxBits+1:2];
    assign hitF = btbValid[idxF] && (btbTag[idxF] == pc_i[31:BtbIdxBits+2]);

    // gshare index
    assign phtIndex_o      = pc_i[GhrBits+1:2] ^ ghr;
    assign predictTaken_o  = hitF && (btbJump[idxF] || pht[phtIndex_o][1]);  // jal always taken
    assign predictTarget_o = btbTarget[idxF];

    always_ff @(posedge clk) begin
        if (!stallF_i) begin
            pcD        <= pc_i;
            predTakenD <= predictTaken_o;
        end
        pcE <= pcD;  // Bubbles never write, so no flush needed here
        opE <= opD_i;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BtbEntries; i++)
                btbValid[i] <= 1'b0;
        end else if (btbWe_i) begin
            btbValid[btbIdx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btbWe_i) begin
            btbTag[btbIdx_i]    <= pcE[31:BtbIdxBits+2];
            btbTarget[btbIdx_i] <= btbTarget_i;
            btbJump[btbIdx_i]   <= (opE == opJal);
        end
    end

    // Saturating 2-bit counters
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**GhrBits; i++)
                pht[i] <= 2'b01;  // Weakly not-taken
        end else if (phtWe_i) begin
            if (phtTaken_i && pht[phtIdx_i] != 2'b11)
                pht[phtIdx_i] <= pht[phtIdx_i] + 2'd1;
            else if (!phtTaken_i && pht[phtIdx_i] != 2'b00)
                pht[phtIdx_i] <= pht[phtIdx_i] - 2'd1;
        end
    end

    // Speculative history; a branch shifts once as it leaves fetch
    always_ff @(posedge clk) begin
        if (reset)
            ghr <= '0;
        else if (ghrRestore_i)
            ghr <= ghrRestoreVal_i;
        else if (opD_i == opBranch && !stallF_i)
            ghr <= {ghr[GhrBits-2:0], predTakenD};
    end

endmodule

`default_nettype wire

// ==== verilog/riscvPkg.sv ====
`default_nettype none

package riscvPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // RV32I opcodes used by this subset
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    typedef enum logic [2:0] {immI, immS, immB, immJ, immU} immSrc_e;
    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_e;
    typedef enum logic [1:0] {fwdNone, fwdWb, fwdMem} fwd_e;
    typedef enum logic [1:0] {resAlu, resMem, resPcPlus4, resImm} resultSrc_e;

    // Predictor geometry, PHT has 2**GhrBits counters
    localparam int BtbEntries = 32;
    localparam int BtbIdxBits = 5;
    localparam int GhrBits    = 5;

    localparam int DmemWords = 64;

    localparam word_t resetPc = 32'h0000_0000;

endpackage

`default_nettype wire
